// File: bench/rs_checker.sv
`timescale 1ns/1ps

module rs_checker
    import rs_cfg_pkg::*, rs_types_pkg::*;
(
    input  logic                                   clock,
    input  logic                                   reset,
    input  dispatch_packet_t [dispatch_width-1:0]  dispatch,
    input  cdb_packet_t      [cdb_width-1:0]       cdb,
    input  logic             [num_alu-1:0]         alu_busy,
    input  logic             [num_mult-1:0]        mult_busy,
    input  issue_packet_t    [num_alu-1:0]         alu_issue,
    input  issue_packet_t    [num_mult-1:0]        mult_issue,
    input  logic             [lane_count_bits-1:0] open_entries,
    output int                                     mismatch_count
);

    // Reference copy of the table and the issue registers it implies
    rs_entry_t     model [rs_depth];
    issue_packet_t exp_alu [num_alu];
    issue_packet_t exp_mult [num_mult];
    string         test_name;

    // Unit takes the ready slot whose rank equals the count of free units below it
    function automatic int granted_slot(fu_class_t cls, int unit, int busy_bits);
        int rank;
        int seen;
        rank = 0;
        seen = 0;
        for (int u = 0; u < unit; u++) begin
            rank += busy_bits[u] ? 0 : 1;
        end
        for (int s = 0; s < rs_depth; s++) begin
            if (!busy_bits[unit] && model[s].valid && model[s].fu == cls &&
                model[s].src1.ready && model[s].src2.ready) begin
                if (seen == rank) begin
                    return s;
                end
                seen++;
            end
        end
        return -1;
    endfunction

    function automatic issue_packet_t expected_issue(fu_class_t cls, int unit, int busy_bits);
        issue_packet_t p;
        int s;
        p = '0;
        s = granted_slot(cls, unit, busy_bits);
        if (s >= 0) begin
            p.valid = 1'b1;
            p.op = model[s].op;
            p.dest = model[s].dest;
            p.src1_tag = model[s].src1.tag;
            p.src2_tag = model[s].src2.tag;
        end
        return p;
    endfunction

    function automatic int expected_open();
        int n;
        n = 0;
        for (int s = 0; s < rs_depth; s++) begin
            n += model[s].valid ? 0 : 1;
        end
        return (n < dispatch_width) ? n : dispatch_width;
    endfunction

    function automatic rs_entry_t woken(rs_entry_t e);
        rs_entry_t r;
        r = e;
        for (int c = 0; c < cdb_width; c++) begin
            if (cdb[c].valid && cdb[c].tag == e.src1.tag) begin
                r.src1.ready = 1'b1;
            end
            if (cdb[c].valid && cdb[c].tag == e.src2.tag) begin
                r.src2.ready = 1'b1;
            end
        end
        return r;
    endfunction

    // Grants come from the table as it stood before this edge
    always @(posedge clock) begin
        logic released [rs_depth];
        logic was_free [rs_depth];
        int s;
        for (int i = 0; i < rs_depth; i++) begin
            released[i] = 1'b0;
        end
        if (reset) begin
            for (int i = 0; i < rs_depth; i++) begin
                model[i] = '0;
            end
            for (int u = 0; u < num_alu; u++) begin
                exp_alu[u] = '0;
            end
            for (int u = 0; u < num_mult; u++) begin
                exp_mult[u] = '0;
            end
        end else begin
            for (int u = 0; u < num_alu; u++) begin
                exp_alu[u] = expected_issue(fu_alu, u, int'(alu_busy));
                s = granted_slot(fu_alu, u, int'(alu_busy));
                if (s >= 0) begin
                    released[s] = 1'b1;
                end
            end
            for (int u = 0; u < num_mult; u++) begin
                exp_mult[u] = expected_issue(fu_mult, u, int'(mult_busy));
                s = granted_slot(fu_mult, u, int'(mult_busy));
                if (s >= 0) begin
                    released[s] = 1'b1;
                end
            end
            for (int i = 0; i < rs_depth; i++) begin
                was_free[i] = !model[i].valid;
                if (released[i]) begin
                    model[i].valid = 1'b0;
                end else if (model[i].valid) begin
                    model[i] = woken(model[i]);
                end
            end
            // A slot freed at this edge is not offered to dispatch yet
            for (int l = 0; l < dispatch_width; l++) begin
                s = -1;
                for (int i = rs_depth - 1; i >= 0; i--) begin
                    if (dispatch[l].valid && was_free[i]) begin
                        s = i;
                    end
                end
                if (s >= 0) begin
                    was_free[s] = 1'b0;
                    model[s] = woken(dispatch[l]);
                    model[s].valid = 1'b1;
                end
            end
        end
    end

    task automatic compare_issue(string port, issue_packet_t expected, issue_packet_t actual);
        if (expected.valid !== actual.valid || (expected.valid && expected !== actual)) begin
            mismatch_count++;
            $display("error %0s: %0s expected %h actual %h", test_name, port, expected, actual);
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            mismatch_count = 0;
        end else begin
            for (int u = 0; u < num_alu; u++) begin
                compare_issue($sformatf("alu_issue[%0d]", u), exp_alu[u], alu_issue[u]);
            end
            for (int u = 0; u < num_mult; u++) begin
                compare_issue($sformatf("mult_issue[%0d]", u), exp_mult[u], mult_issue[u]);
            end
            if (int'(open_entries) != expected_open()) begin
                mismatch_count++;
                $display("error %0s: open_entries expected %0d actual %0d",
                         test_name, expected_open(), open_entries);
            end
        end
    end

endmodule

// File: bench/rs_tb.sv
`timescale 1ns/1ps

module rs_tb
    import rs_cfg_pkg::*, rs_types_pkg::*;
();

    localparam int half_period = 50;
    localparam int reset_cycles = 4;
    localparam int random_cycles = 2000;
    // Lengths of the five tests with room for the drains
    localparam int test_cycles = 10 + 10 + 20 + 40 + random_cycles;
    localparam int timeout_margin = 200;
    localparam int cycle_limit = reset_cycles + test_cycles + timeout_margin;

    logic                                   clock;
    logic                                   reset;
    dispatch_packet_t [dispatch_width-1:0]  dispatch;
    cdb_packet_t      [cdb_width-1:0]       cdb;
    logic             [num_alu-1:0]         alu_busy;
    logic             [num_mult-1:0]        mult_busy;
    issue_packet_t    [num_alu-1:0]         alu_issue;
    issue_packet_t    [num_mult-1:0]        mult_issue;
    logic             [lane_count_bits-1:0] open_entries;
    int                                     mismatch_count;
    int check_errors = 0;
    int start_errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    int cycle_count = 0;
    string test_name;

    reservation_station i_reservation_station (.*);

    rs_checker i_checker (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #half_period clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic tick();
        @(negedge clock);
        dispatch = '0;
        cdb = '0;
    endtask

    function automatic dispatch_packet_t make_op(fu_class_t fu, int op, int dest,
                                                 int tag1, logic rdy1, int tag2, logic rdy2);
        dispatch_packet_t p;
        p.valid = 1'b1;
        p.fu = fu;
        p.op = op_bits'(op);
        p.dest = preg_bits'(dest);
        p.src1.tag = preg_bits'(tag1);
        p.src1.ready = rdy1;
        p.src2.tag = preg_bits'(tag2);
        p.src2.ready = rdy2;
        return p;
    endfunction

    function automatic int issue_count();
        int n;
        n = 0;
        for (int u = 0; u < num_alu; u++) begin
            n += int'(alu_issue[u].valid);
        end
        for (int u = 0; u < num_mult; u++) begin
            n += int'(mult_issue[u].valid);
        end
        return n;
    endfunction

    task automatic check_value(string what, int expected, int actual);
        if (expected != actual) begin
            check_errors++;
            $display("error %0s: %0s expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    // Reports at a rising edge away from the checker's falling-edge compares
    task automatic end_test(string next_name);
        int errors;
        @(posedge clock);
        errors = mismatch_count + check_errors - start_errors;
        if (errors == 0) begin
            pass_count++;
            $display("test %0s: ok", test_name);
        end else begin
            fail_count++;
            $display("test %0s: %0d errors", test_name, errors);
        end
        test_name = next_name;
        i_checker.test_name = next_name;
        start_errors = mismatch_count + check_errors;
        @(negedge clock);
    endtask

    initial begin
        int filled;
        int drained;
        void'($urandom(32'he731));
        test_name = "after_reset";
        i_checker.test_name = test_name;
        reset = 1'b1;
        dispatch = '0;
        cdb = '0;
        alu_busy = '0;
        mult_busy = '0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        repeat (6) begin
            tick();
            check_value("issue valids", 0, issue_count());
            check_value("open_entries", dispatch_width, int'(open_entries));
        end

        end_test("ready_dispatch");
        dispatch[0] = make_op(fu_alu, 1, 10, 1, 1'b1, 2, 1'b1);
        dispatch[1] = make_op(fu_alu, 2, 11, 3, 1'b1, 4, 1'b1);
        tick();
        dispatch[0] = make_op(fu_mult, 3, 12, 5, 1'b1, 6, 1'b1);
        tick();
        check_value("alu_issue[0].valid", 1, int'(alu_issue[0].valid));
        check_value("alu_issue[0].dest", 10, int'(alu_issue[0].dest));
        check_value("alu_issue[1].valid", 1, int'(alu_issue[1].valid));
        check_value("alu_issue[1].dest", 11, int'(alu_issue[1].dest));
        tick();
        check_value("mult_issue[0].valid", 1, int'(mult_issue[0].valid));
        check_value("mult_issue[0].op", 3, int'(mult_issue[0].op));
        repeat (3) tick();

        end_test("wakeup");
        dispatch[0] = make_op(fu_alu, 4, 30, 22, 1'b0, 7, 1'b1);
        dispatch[1] = make_op(fu_alu, 5, 31, 8, 1'b1, 21, 1'b0);
        cdb[0].valid = 1'b1;
        cdb[0].tag = 6'd21;
        tick();
        dispatch[0] = make_op(fu_alu, 6, 32, 22, 1'b0, 9, 1'b1);
        tick();
        check_value("alu_issue[0].dest", 31, int'(alu_issue[0].dest));
        check_value("issue valids", 1, issue_count());
        repeat (3) begin
            tick();
            check_value("issue valids", 0, issue_count());
        end
        cdb[1].valid = 1'b1;
        cdb[1].tag = 6'd22;
        tick();
        tick();
        check_value("alu_issue[0].dest", 30, int'(alu_issue[0].dest));
        check_value("alu_issue[1].dest", 32, int'(alu_issue[1].dest));
        check_value("issue valids", 2, issue_count());
        repeat (2) tick();

        end_test("backpressure");
        alu_busy = '1;
        mult_busy = '1;
        filled = 0;
        while (filled < rs_depth) begin
            for (int l = 0; l < dispatch_width; l++) begin
                if (l < int'(open_entries) && filled < rs_depth) begin
                    dispatch[l] = make_op(fu_alu, filled, 40 + filled, 1, 1'b1, 2, 1'b1);
                    filled++;
                end
            end
            tick();
            check_value("issue valids", 0, issue_count());
        end
        check_value("open_entries", 0, int'(open_entries));
        // Unit 1 drains the table while unit 0 stays busy
        alu_busy = 2'b01;
        drained = 0;
        while (drained < rs_depth) begin
            tick();
            check_value("alu_issue[0].valid", 0, int'(alu_issue[0].valid));
            if (alu_issue[1].valid) begin
                check_value("alu_issue[1].dest", 40 + drained, int'(alu_issue[1].dest));
                drained++;
            end
        end
        alu_busy = '0;
        mult_busy = '0;
        tick();

        end_test("random_mix");
        repeat (random_cycles) begin
            for (int l = 0; l < dispatch_width; l++) begin
                if (l < int'(open_entries) && $urandom_range(0, 3) != 0) begin
                    dispatch[l] = make_op($urandom_range(0, 1) == 0 ? fu_alu : fu_mult,
                                          $urandom_range(0, 15), $urandom_range(0, 63),
                                          $urandom_range(0, 15), 1'($urandom_range(0, 1)),
                                          $urandom_range(0, 15), 1'($urandom_range(0, 1)));
                end
            end
            for (int c = 0; c < cdb_width; c++) begin
                cdb[c].valid = 1'($urandom_range(0, 1));
                cdb[c].tag = preg_bits'($urandom_range(0, 15));
            end
            alu_busy = num_alu'($urandom_range(0, 3));
            mult_busy = num_mult'($urandom_range(0, 1));
            tick();
        end
        alu_busy = '0;
        mult_busy = '0;
        end_test("done");
        // Compares made after the last report still count
        @(posedge clock);
        if (mismatch_count + check_errors != start_errors) begin
            fail_count++;
        end

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: hw/reservation_station.sv
`timescale 1ns/1ps

module reservation_station
    import rs_cfg_pkg::*, rs_types_pkg::*;
(
    input  logic                                   clock,
    input  logic                                   reset,

    // Decoded instructions, at most open_entries lanes valid
    input  dispatch_packet_t [dispatch_width-1:0]  dispatch,
    // Completion tags that wake waiting sources
    input  cdb_packet_t      [cdb_width-1:0]       cdb,

    input  logic             [num_alu-1:0]         alu_busy,
    input  logic             [num_mult-1:0]        mult_busy,

    output issue_packet_t    [num_alu-1:0]         alu_issue,
    output issue_packet_t    [num_mult-1:0]        mult_issue,
    output logic             [lane_count_bits-1:0] open_entries
);

    rs_issue_if i_issue_bus ();

    rs_entry_table i_entry_table (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .issue        (i_issue_bus.tbl),
        .open_entries (open_entries)
    );

    rs_issue_stage i_issue_stage (
        .clock      (clock),
        .reset      (reset),
        .issue      (i_issue_bus.issue),
        .alu_busy   (alu_busy),
        .mult_busy  (mult_busy),
        .alu_issue  (alu_issue),
        .mult_issue (mult_issue)
    );

endmodule

// File: hw/rs_cfg_pkg.sv
package rs_cfg_pkg;

    // Table size and per-cycle bandwidth
    localparam int rs_depth = 8;
    localparam int dispatch_width = 2;
    localparam int cdb_width = 2;

    // Functional units behind the station
    localparam int num_alu = 2;
    localparam int num_mult = 1;

    // Field widths
    localparam int preg_bits = 6;
    localparam int op_bits = 4;

    // Index of one entry, rs_depth = 2**slot_bits
    localparam int slot_bits = 3;

    // Holds 0 up to dispatch_width
    localparam int lane_count_bits = 2;

endpackage

// File: hw/rs_entry_table.sv
`timescale 1ns/1ps

module rs_entry_table
    import rs_cfg_pkg::*, rs_types_pkg::*;
(
    input  logic                                   clock,
    input  logic                                   reset,
    input  dispatch_packet_t [dispatch_width-1:0]  dispatch,
    input  cdb_packet_t      [cdb_width-1:0]       cdb,
    rs_issue_if.tbl                                issue,
    output logic             [lane_count_bits-1:0] open_entries
);

    rs_entry_t [rs_depth-1:0]               entries_q;
    rs_entry_t [rs_depth-1:0]               entries_next;
    logic [rs_depth-1:0]                    free_mask;
    logic [dispatch_width-1:0]              lane_valid;
    logic [dispatch_width-1:0][rs_depth-1:0] slot_grant;
    logic [slot_bits:0]                     free_count;

    // Marks sources whose tag is on the completion bus
    function automatic rs_entry_t wake(rs_entry_t e, cdb_packet_t [cdb_width-1:0] bus);
        rs_entry_t r;
        r = e;
        for (int c = 0; c < cdb_width; c++) begin
            if (bus[c].valid) begin
                if (e.src1.tag == bus[c].tag) begin
                    r.src1.ready = 1'b1;
                end
                if (e.src2.tag == bus[c].tag) begin
                    r.src2.ready = 1'b1;
                end
            end
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            free_mask[i] = ~entries_q[i].valid;
        end
        for (int l = 0; l < dispatch_width; l++) begin
            lane_valid[l] = dispatch[l].valid;
        end
    end

    // Slots freed by this cycle's issue are not offered until next cycle
    rs_slot_alloc i_slot_alloc (
        .free_mask  (free_mask),
        .lane_valid (lane_valid),
        .slot_grant (slot_grant)
    );

    always_comb begin
        entries_next = entries_q;
        for (int i = 0; i < rs_depth; i++) begin
            if (issue.issued_mask[i]) begin
                entries_next[i].valid = 1'b0;
            end else if (entries_q[i].valid) begin
                entries_next[i] = wake(entries_q[i], cdb);
            end
        end
        // New instructions see the same completion tags as stored ones
        for (int l = 0; l < dispatch_width; l++) begin
            for (int i = 0; i < rs_depth; i++) begin
                if (slot_grant[l][i]) begin
                    entries_next[i] = wake(dispatch[l], cdb);
                    entries_next[i].valid = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rs_depth; i++) begin
                entries_q[i].valid <= 1'b0;
            end
        end else begin
            entries_q <= entries_next;
        end
    end

    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            issue.alu_ready[i] = entries_q[i].valid && entries_q[i].src1.ready &&
                                 entries_q[i].src2.ready && entries_q[i].fu == fu_alu;
            issue.mult_ready[i] = entries_q[i].valid && entries_q[i].src1.ready &&
                                  entries_q[i].src2.ready && entries_q[i].fu == fu_mult;
        end
    end

    assign issue.entries = entries_q;

    always_comb begin
        free_count = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (free_mask[i]) begin
                free_count = free_count + (slot_bits + 1)'(1);
            end
        end
    end

    assign open_entries = (int'(free_count) >= dispatch_width)
                          ? lane_count_bits'(dispatch_width)
                          : free_count[lane_count_bits-1:0];

    // Upstream honours the free count reported for this cycle
    a_lane_bound: assert property (@(posedge clock) disable iff (reset)
        $countones(lane_valid) <= int'(open_entries))
        else $error("more valid dispatch lanes than open entries");

    // Issue stage only grants occupied slots
    a_issue_occupied: assert property (@(posedge clock) disable iff (reset)
        (issue.issued_mask & free_mask) == '0)
        else $error("issued slot is not occupied");

endmodule

// File: hw/rs_issue_if.sv
`timescale 1ns/1ps

interface rs_issue_if
    import rs_cfg_pkg::*, rs_types_pkg::*;
    ();

    rs_entry_t [rs_depth-1:0] entries;
    // Per-slot issue requests, one mask per unit class
    logic [rs_depth-1:0]      alu_ready;
    logic [rs_depth-1:0]      mult_ready;
    // Slots granted this cycle, freed at the next edge
    logic [rs_depth-1:0]      issued_mask;

    modport tbl (
        output entries,
        output alu_ready,
        output mult_ready,
        input  issued_mask
    );

    modport issue (
        input  entries,
        input  alu_ready,
        input  mult_ready,
        output issued_mask
    );

endinterface

// File: hw/rs_issue_select.sv
`timescale 1ns/1ps

module rs_issue_select
    import rs_cfg_pkg::*;
#(
    parameter int num_fu = 2
)
(
    input  logic [rs_depth-1:0]             ready_mask,
    input  logic [num_fu-1:0]               fu_busy,
    output logic [num_fu-1:0][rs_depth-1:0] fu_grant,
    output logic [rs_depth-1:0]             taken
);

    // Free units in index order each take the lowest remaining ready slot
    always_comb begin
        logic [rs_depth-1:0] pending;
        pending = ready_mask;
        taken = '0;
        for (int u = 0; u < num_fu; u++) begin
            fu_grant[u] = '0;
            if (!fu_busy[u]) begin
                for (int i = 0; i < rs_depth; i++) begin
                    if (pending[i] && fu_grant[u] == '0) begin
                        fu_grant[u][i] = 1'b1;
                        pending[i] = 1'b0;
                    end
                end
            end
            taken = taken | fu_grant[u];
        end
    end

    always_comb begin
        for (int u = 0; u < num_fu; u++) begin
            assert (!(fu_busy[u] && fu_grant[u] != '0))
                else $error("busy unit %0d holds a grant", u);
        end
    end

endmodule

// File: hw/rs_issue_stage.sv
`timescale 1ns/1ps

module rs_issue_stage
    import rs_cfg_pkg::*, rs_types_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    rs_issue_if.issue                       issue,
    input  logic          [num_alu-1:0]     alu_busy,
    input  logic          [num_mult-1:0]    mult_busy,
    output issue_packet_t [num_alu-1:0]     alu_issue,
    output issue_packet_t [num_mult-1:0]    mult_issue
);

    logic [num_alu-1:0][rs_depth-1:0]  alu_grant;
    logic [num_mult-1:0][rs_depth-1:0] mult_grant;
    logic [rs_depth-1:0]               alu_taken;
    logic [rs_depth-1:0]               mult_taken;
    issue_packet_t [num_alu-1:0]       alu_next;
    issue_packet_t [num_mult-1:0]      mult_next;

    // Packet of the granted slot, or the held payload with valid low
    function automatic issue_packet_t pick(logic [rs_depth-1:0] grant,
                                           rs_entry_t [rs_depth-1:0] entries,
                                           issue_packet_t hold);
        issue_packet_t p;
        p = hold;
        p.valid = 1'b0;
        for (int i = 0; i < rs_depth; i++) begin
            if (grant[i]) begin
                p.valid = 1'b1;
                p.op = entries[i].op;
                p.dest = entries[i].dest;
                p.src1_tag = entries[i].src1.tag;
                p.src2_tag = entries[i].src2.tag;
            end
        end
        return p;
    endfunction

    rs_issue_select #(.num_fu(num_alu)) alu_select (
        .ready_mask (issue.alu_ready),
        .fu_busy    (alu_busy),
        .fu_grant   (alu_grant),
        .taken      (alu_taken)
    );

    rs_issue_select #(.num_fu(num_mult)) mult_select (
        .ready_mask (issue.mult_ready),
        .fu_busy    (mult_busy),
        .fu_grant   (mult_grant),
        .taken      (mult_taken)
    );

    assign issue.issued_mask = alu_taken | mult_taken;

    always_comb begin
        for (int u = 0; u < num_alu; u++) begin
            alu_next[u] = pick(alu_grant[u], issue.entries, alu_issue[u]);
        end
        for (int u = 0; u < num_mult; u++) begin
            mult_next[u] = pick(mult_grant[u], issue.entries, mult_issue[u]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int u = 0; u < num_alu; u++) begin
                alu_issue[u].valid <= 1'b0;
            end
            for (int u = 0; u < num_mult; u++) begin
                mult_issue[u].valid <= 1'b0;
            end
        end else begin
            alu_issue <= alu_next;
            mult_issue <= mult_next;
        end
    end

endmodule

// File: hw/rs_slot_alloc.sv
`timescale 1ns/1ps

module rs_slot_alloc
    import rs_cfg_pkg::*;
(
    input  logic [rs_depth-1:0]                     free_mask,
    input  logic [dispatch_width-1:0]               lane_valid,
    output logic [dispatch_width-1:0][rs_depth-1:0] slot_grant
);

    // Lanes take free slots in lane order, lowest index first
    always_comb begin
        logic [rs_depth-1:0] remaining;
        remaining = free_mask;
        for (int l = 0; l < dispatch_width; l++) begin
            slot_grant[l] = '0;
            if (lane_valid[l]) begin
                for (int i = 0; i < rs_depth; i++) begin
                    if (remaining[i] && slot_grant[l] == '0) begin
                        slot_grant[l][i] = 1'b1;
                        remaining[i] = 1'b0;
                    end
                end
            end
        end
    end

    // Two lanes writing one slot would lose an instruction
    always_comb begin
        for (int a = 0; a < dispatch_width; a++) begin
            for (int b = a + 1; b < dispatch_width; b++) begin
                assert ((slot_grant[a] & slot_grant[b]) == '0)
                    else $error("lanes %0d and %0d share a slot", a, b);
            end
        end
    end

endmodule

// File: hw/rs_types_pkg.sv
package rs_types_pkg;

    import rs_cfg_pkg::*;

    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_class_t;

    typedef struct packed {
        logic [preg_bits-1:0] tag;
        logic                 ready;
    } src_operand_t;

    // One decoded instruction on a dispatch lane
    typedef struct packed {
        logic                 valid;
        fu_class_t            fu;
        logic [op_bits-1:0]   op;
        logic [preg_bits-1:0] dest;
        src_operand_t         src1;
        src_operand_t         src2;
    } dispatch_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [preg_bits-1:0] tag;
    } cdb_packet_t;

    // Stored form of a dispatched instruction, valid marks an occupied slot
    typedef dispatch_packet_t rs_entry_t;

    // What a unit receives when an entry issues
    typedef struct packed {
        logic                 valid;
        logic [op_bits-1:0]   op;
        logic [preg_bits-1:0] dest;
        logic [preg_bits-1:0] src1_tag;
        logic [preg_bits-1:0] src2_tag;
    } issue_packet_t;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rs_tb -f sources.f -o rs_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rs_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

// File: sources.f
hw/rs_cfg_pkg.sv
hw/rs_types_pkg.sv
hw/rs_issue_if.sv
hw/rs_slot_alloc.sv
hw/rs_entry_table.sv
hw/rs_issue_select.sv
hw/rs_issue_stage.sv
hw/reservation_station.sv
bench/rs_checker.sv
bench/rs_tb.sv
